// File: Makefile
VERILATOR ?= verilator
TOP       ?= vgaController_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/backgroundRom.sv
`timescale 1ns/1ns

module backgroundRom (
	input  logic            VGA_CLK_n,
	input  logic [2:0]      tileX,
	input  logic [2:0]      tileY,
	output vgaPkg::palIdx_t index
);
	import vgaPkg::*;

	palIdx_t tileMap [0:63];

	initial
	begin
		$readmemh("rtl/bgTiles.hex", tileMap);
	end

	// Row-major map, tileY * 8 + tileX
	always_ff @(posedge VGA_CLK_n)
	begin
		index <= tileMap[{tileY, tileX}];
	end

endmodule

// File: rtl/bgTiles.hex
// Palette index per 64x64 tile, row-major, entry tileY * 8 + tileX
0
1
2
3
4
5
6
7
3
4
5
6
7
8
9
a
6
7
8
9
a
b
c
d
9
a
b
c
d
e
f
0
c
d
e
f
0
1
2
3
f
0
1
2
3
4
5
6
2
3
4
5
6
7
8
9
5
6
7
8
9
a
b
c

// File: rtl/pixelComposer.sv
`timescale 1ns/1ns

module pixelComposer (
	input  logic                VGA_CLK_n,
	input  logic                iRST_n,
	input  vgaPkg::coord_t      pixX,
	input  vgaPkg::coord_t      pixY,
	input  logic                hsync,
	input  logic                vsync,
	input  logic                blankN,
	input  vgaPkg::spriteDesc_t activeSprites [0:vgaPkg::SPRITE_COUNT-1],
	output logic                oHS,
	output logic                oVS,
	output logic                oBLANK_n,
	output vgaPkg::vgaPixel_t   pixel
);
	import vgaPkg::*;

	palIdx_t                 bgIndex;
	logic [SPRITE_COUNT-1:0] hitS1;
	logic                    hsS1;
	logic                    vsS1;
	logic                    blankNS1;
	vgaPixel_t               colour;

	// Half-open on both axes, end computed one bit wider
	function automatic logic insideRect(input spriteDesc_t s, input coord_t px,
		input coord_t py);
		logic [16:0] xEnd;
		logic [16:0] yEnd;
		xEnd = {1'b0, s.x} + {1'b0, s.width};
		yEnd = {1'b0, s.y} + {1'b0, s.height};
		return (px >= s.x) && ({1'b0, px} < xEnd) &&
			(py >= s.y) && ({1'b0, py} < yEnd);
	endfunction

	// Stage 1, tile lookup runs beside the hit tests
	backgroundRom bgRom (
		.VGA_CLK_n (VGA_CLK_n),
		.tileX     (pixX[TILE_SHIFT+2:TILE_SHIFT]),
		.tileY     (pixY[TILE_SHIFT+2:TILE_SHIFT]),
		.index     (bgIndex)
	);

	always_ff @(posedge VGA_CLK_n)
	begin
		for (int k = 0; k < SPRITE_COUNT; k++)
			hitS1[k] <= insideRect(activeSprites[k], pixX, pixY);
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			hsS1     <= 1'b1;
			vsS1     <= 1'b1;
			blankNS1 <= 1'b0;
		end
		else
		begin
			hsS1     <= hsync;
			vsS1     <= vsync;
			blankNS1 <= blankN;
		end
	end

	// Frontmost wins: player 1, player 2, stage, background
	always_comb
	begin
		if (hitS1[0])
			colour = P1_COLOR;
		else if (hitS1[1])
			colour = P2_COLOR;
		else if (hitS1[2])
			colour = STAGE_COLOR;
		else
			colour = PALETTE[bgIndex];
	end

	// Stage 2
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			oHS      <= 1'b1;
			oVS      <= 1'b1;
			oBLANK_n <= 1'b0;
			pixel    <= '0;
		end
		else
		begin
			oHS      <= hsS1;
			oVS      <= vsS1;
			oBLANK_n <= blankNS1;
			pixel    <= blankNS1 ? colour : '0;
		end
	end

endmodule

// File: rtl/spriteRegs.sv
`timescale 1ns/1ns

module spriteRegs (
	input  logic                VGA_CLK_n,
	input  logic                iRST_n,
	input  logic                cyc,
	input  logic                stb,
	input  logic                we,
	input  vgaPkg::wbAddr_t     adr,
	input  vgaPkg::wbData_t     datIn,
	output vgaPkg::wbData_t     datOut,
	output logic                ack,
	input  logic                frameStart,
	output vgaPkg::spriteDesc_t activeSprites [0:vgaPkg::SPRITE_COUNT-1]
);
	import vgaPkg::*;

	spriteDesc_t pending   [0:SPRITE_COUNT-1];
	spriteDesc_t activeReg [0:SPRITE_COUNT-1];
	logic        request;
	logic [1:0]  sel;
	logic        hiHalf;
	wbData_t     readWord;

	// New request only, so a held stb gets one ack
	assign request = cyc && stb && !ack;
	assign sel     = adr[2:1];
	assign hiHalf  = adr[0];

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
			ack <= 1'b0;
		else
			ack <= request;
	end

	// Pending set, host side
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			for (int k = 0; k < SPRITE_COUNT; k++)
				pending[k] <= '0;
		end
		else if (request && we)
		begin
			for (int k = 0; k < SPRITE_COUNT; k++)
			begin
				if (sel == k[1:0])
				begin
					if (hiHalf)
						pending[k][63:32] <= datIn;
					else
						pending[k][31:0] <= datIn;
				end
			end
		end
	end

	// Words 6 and 7 fall through as zero
	always_comb
	begin
		readWord = '0;
		for (int k = 0; k < SPRITE_COUNT; k++)
		begin
			if (sel == k[1:0])
				readWord = hiHalf ? pending[k][63:32] : pending[k][31:0];
		end
	end

	always_ff @(posedge VGA_CLK_n)
	begin
		if (request && !we)
			datOut <= readWord;
	end

	// Active set swaps once per frame
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			for (int k = 0; k < SPRITE_COUNT; k++)
				activeReg[k] <= '0;
		end
		else if (frameStart)
		begin
			for (int k = 0; k < SPRITE_COUNT; k++)
				activeReg[k] <= pending[k];
		end
	end

	// Pixel (0,0) is sampled on the copy edge itself, so pass the pending set through
	always_comb
	begin
		for (int k = 0; k < SPRITE_COUNT; k++)
			activeSprites[k] = frameStart ? pending[k] : activeReg[k];
	end

endmodule

// File: rtl/vgaController.sv
`timescale 1ns/1ns

module vgaController (
	input  logic              VGA_CLK_n,
	input  logic              iRST_n,
	input  logic              cyc,
	input  logic              stb,
	input  logic              we,
	input  vgaPkg::wbAddr_t   adr,
	input  vgaPkg::wbData_t   datIn,
	output vgaPkg::wbData_t   datOut,
	output logic              ack,
	output logic              oHS,
	output logic              oVS,
	output logic              oBLANK_n,
	output vgaPkg::vgaPixel_t pixel
);
	import vgaPkg::*;

	coord_t      pixX;
	coord_t      pixY;
	logic        hsync;
	logic        vsync;
	logic        blankN;
	logic        frameStart;
	spriteDesc_t activeSprites [0:SPRITE_COUNT-1];

	videoSyncGenerator syncGen (
		.VGA_CLK_n  (VGA_CLK_n),
		.iRST_n     (iRST_n),
		.pixX       (pixX),
		.pixY       (pixY),
		.hsync      (hsync),
		.vsync      (vsync),
		.blankN     (blankN),
		.frameStart (frameStart)
	);

	// Host side
	spriteRegs regs (
		.VGA_CLK_n     (VGA_CLK_n),
		.iRST_n        (iRST_n),
		.cyc           (cyc),
		.stb           (stb),
		.we            (we),
		.adr           (adr),
		.datIn         (datIn),
		.datOut        (datOut),
		.ack           (ack),
		.frameStart    (frameStart),
		.activeSprites (activeSprites)
	);

	pixelComposer composer (
		.VGA_CLK_n     (VGA_CLK_n),
		.iRST_n        (iRST_n),
		.pixX          (pixX),
		.pixY          (pixY),
		.hsync         (hsync),
		.vsync         (vsync),
		.blankN        (blankN),
		.activeSprites (activeSprites),
		.oHS           (oHS),
		.oVS           (oVS),
		.oBLANK_n      (oBLANK_n),
		.pixel         (pixel)
	);

endmodule

// File: rtl/vgaPkg.sv
package vgaPkg;

	// Widths with a meaning of their own
	typedef logic [15:0] coord_t;
	typedef logic [7:0]  color_t;
	typedef logic [3:0]  palIdx_t;
	typedef logic [2:0]  wbAddr_t;
	typedef logic [31:0] wbData_t;

	// Low word is {y, x}, high word is {height, width}
	typedef struct packed {
		coord_t height;
		coord_t width;
		coord_t y;
		coord_t x;
	} spriteDesc_t;

	typedef struct packed {
		color_t r;
		color_t g;
		color_t b;
	} vgaPixel_t;

	// 640x480 at 60 Hz
	localparam coord_t H_ACTIVE = 16'd640;
	localparam coord_t H_FRONT  = 16'd16;
	localparam coord_t H_SYNC   = 16'd96;
	localparam coord_t H_TOTAL  = 16'd800;
	localparam coord_t V_ACTIVE = 16'd480;
	localparam coord_t V_FRONT  = 16'd10;
	localparam coord_t V_SYNC   = 16'd2;
	localparam coord_t V_TOTAL  = 16'd525;

	// 0 is player 1, 1 is player 2, 2 is the stage
	localparam int SPRITE_COUNT = 3;

	localparam vgaPixel_t P1_COLOR    = 24'hff0000;
	localparam vgaPixel_t P2_COLOR    = 24'h0000ff;
	localparam vgaPixel_t STAGE_COLOR = 24'hffffff;

	// 64x64 tiles, map wraps every 8 tiles
	localparam int TILE_SHIFT = 6;

	localparam vgaPixel_t PALETTE [0:15] = '{
		24'h000000, 24'h1d2b53, 24'h7e2553, 24'h008751,
		24'hab5236, 24'h5f574f, 24'hc2c3c7, 24'hfff1e8,
		24'hff004d, 24'hffa300, 24'hffec27, 24'h00e436,
		24'h29adff, 24'h83769c, 24'hff77a8, 24'hffccaa
	};

endpackage

// File: rtl/videoSyncGenerator.sv
`timescale 1ns/1ns

module videoSyncGenerator (
	input  logic           VGA_CLK_n,
	input  logic           iRST_n,
	output vgaPkg::coord_t pixX,
	output vgaPkg::coord_t pixY,
	output logic           hsync,
	output logic           vsync,
	output logic           blankN,
	output logic           frameStart
);
	import vgaPkg::*;

	coord_t hCount;
	coord_t vCount;
	coord_t hNext;
	coord_t vNext;

	// Position of the coming cycle
	always_comb
	begin
		hNext = hCount + 16'd1;
		vNext = vCount;
		if (hCount == H_TOTAL - 16'd1)
		begin
			hNext = '0;
			if (vCount == V_TOTAL - 16'd1)
				vNext = '0;
			else
				vNext = vCount + 16'd1;
		end
	end

	// Controls decoded from the next count so they line up with it
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			// Parked on the last count, first clock lands on (0,0)
			hCount     <= H_TOTAL - 16'd1;
			vCount     <= V_TOTAL - 16'd1;
			hsync      <= 1'b1;
			vsync      <= 1'b1;
			blankN     <= 1'b0;
			frameStart <= 1'b0;
		end
		else
		begin
			hCount     <= hNext;
			vCount     <= vNext;
			hsync      <= !((hNext >= H_ACTIVE + H_FRONT) &&
				(hNext < H_ACTIVE + H_FRONT + H_SYNC));
			vsync      <= !((vNext >= V_ACTIVE + V_FRONT) &&
				(vNext < V_ACTIVE + V_FRONT + V_SYNC));
			blankN     <= (hNext < H_ACTIVE) && (vNext < V_ACTIVE);
			frameStart <= (hNext == '0) && (vNext == '0);
		end
	end

	assign pixX = hCount;
	assign pixY = vCount;

endmodule

// File: src.f
rtl/vgaPkg.sv
rtl/videoSyncGenerator.sv
rtl/spriteRegs.sv
rtl/backgroundRom.sv
rtl/pixelComposer.sv
rtl/vgaController.sv
testbench/vgaController_chk.sv
testbench/vgaController_tb.sv

// File: testbench/vgaController_chk.sv
`timescale 1ns/1ns

module vgaController_chk (
	input logic              VGA_CLK_n,
	input logic              iRST_n,
	input logic              cyc,
	input logic              stb,
	input logic              ack,
	input logic              oHS,
	input logic              oBLANK_n,
	input vgaPkg::vgaPixel_t pixel
);
	int hsLowRun;
	int failures = 0;

	// Consecutive cycles with oHS low
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
			hsLowRun <= 0;
		else if (!oHS)
			hsLowRun <= hsLowRun + 1;
		else
			hsLowRun <= 0;
	end

	ackSingle: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n) ack |=> !ack)
	else
	begin
		$error("ack stayed high for two cycles");
		failures++;
	end

	ackRequested: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		ack |-> $past(cyc && stb))
	else
	begin
		$error("ack without a cyc and stb request in the previous cycle");
		failures++;
	end

	hsWidth: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		$rose(oHS) |-> hsLowRun == 96)
	else
	begin
		$error("oHS low pulse was not 96 cycles wide");
		failures++;
	end

	blankDark: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!oBLANK_n |-> pixel == '0)
	else
	begin
		$error("pixel not black during blanking");
		failures++;
	end

endmodule

bind vgaController vgaController_chk chk (
	.VGA_CLK_n (VGA_CLK_n),
	.iRST_n    (iRST_n),
	.cyc       (cyc),
	.stb       (stb),
	.ack       (ack),
	.oHS       (oHS),
	.oBLANK_n  (oBLANK_n),
	.pixel     (pixel)
);

// File: testbench/vgaController_tb.sv
`timescale 1ns/1ns

module vgaController_tb;
	import vgaPkg::*;

	logic        VGA_CLK_n;
	logic        iRST_n;
	logic        cyc;
	logic        stb;
	logic        we;
	wbAddr_t     adr;
	wbData_t     datIn;
	wbData_t     datOut;
	logic        ack;
	logic        oHS;
	logic        oVS;
	logic        oBLANK_n;
	vgaPixel_t   pixel;

	int          errors = 0;
	int          seed;
	int          cycleCount = 0;
	palIdx_t     tileRef [0:63];
	spriteDesc_t pendingRef [0:2];
	spriteDesc_t activeRef [0:2];
	vgaPixel_t   lineBuf [0:639];

	// Tracker and timing monitor state
	int          col = 0;
	int          line = 0;
	int          frameCount = 0;
	int          checkFrom = 0;
	int          checkUntil = 0;
	int          captureFrame = -1;
	int          pixelChecks = 0;
	logic        timingOn = 1'b0;
	int          hsFall = 0;
	int          vsFall = 0;
	int          vsFalls = 0;
	int          lineTotal = 0;
	int          activeLines = 0;
	logic        seenVs = 1'b1;
	logic        prevHs = 1'b1;
	logic        prevVs = 1'b1;
	logic        prevBlank = 1'b0;

	vgaController uut (.*);

	initial
	begin
		VGA_CLK_n = 1'b0;
		forever #2 VGA_CLK_n = ~VGA_CLK_n;
	end

	task automatic checkHex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic logic covers(input spriteDesc_t s, input int px, input int py);
		return px >= int'(s.x) && px < int'(s.x) + int'(s.width) &&
			py >= int'(s.y) && py < int'(s.y) + int'(s.height);
	endfunction

	function automatic vgaPixel_t backgroundColour(input int px, input int py);
		logic [5:0] entry;
		entry = 6'(((py / 64) % 8) * 8 + (px / 64) % 8);
		return PALETTE[tileRef[entry]];
	endfunction

	function automatic vgaPixel_t expectedColour(input int px, input int py);
		if (covers(activeRef[0], px, py))
			return P1_COLOR;
		if (covers(activeRef[1], px, py))
			return P2_COLOR;
		if (covers(activeRef[2], px, py))
			return STAGE_COLOR;
		return backgroundColour(px, py);
	endfunction

	task automatic wbWrite(input wbAddr_t a, input wbData_t d);
		@(negedge VGA_CLK_n);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datIn = d;
		do
			@(negedge VGA_CLK_n);
		while (!ack);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		if (a < 3'd6)
		begin
			if (a[0])
				pendingRef[a[2:1]][63:32] = d;
			else
				pendingRef[a[2:1]][31:0] = d;
		end
	endtask

	task automatic wbRead(input wbAddr_t a, output wbData_t d);
		@(negedge VGA_CLK_n);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		do
			@(negedge VGA_CLK_n);
		while (!ack);
		d = datOut;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic waitLine(input int n);
		wait (line == n);
	endtask

	// Sync timing and pixel position, derived from the outputs only
	always @(negedge VGA_CLK_n)
	begin
		if (iRST_n)
		begin
			if (prevHs && !oHS)
			begin
				if (timingOn && hsFall > 0)
					checkHex("oHS period", cycleCount - hsFall, 800);
				hsFall = cycleCount;
				lineTotal++;
			end
			if (!prevHs && oHS && timingOn && hsFall > 0)
				checkHex("oHS low width", cycleCount - hsFall, 96);
			if (prevVs && !oVS)
			begin
				if (timingOn && vsFall > 0)
				begin
					checkHex("oVS lines per frame", lineTotal, 525);
					checkHex("oBLANK_n active lines", activeLines, 480);
				end
				vsFall = cycleCount;
				vsFalls++;
				lineTotal = 0;
				activeLines = 0;
				seenVs = 1'b1;
			end
			if (!prevVs && oVS && timingOn && vsFall > 0)
				checkHex("oVS low width", cycleCount - vsFall, 1600);
			if (oBLANK_n)
			begin
				if (!prevBlank)
				begin
					col = 0;
					if (seenVs)
					begin
						// New frame, the model takes its descriptors now
						line = 0;
						seenVs = 1'b0;
						frameCount++;
						activeRef = pendingRef;
					end
					else
						line++;
				end
				else
					col++;
				if (frameCount >= checkFrom && frameCount < checkUntil)
				begin
					checkHex($sformatf("pixel (%0d,%0d)", col, line), 32'(pixel),
						32'(expectedColour(col, line)));
					pixelChecks++;
				end
				if (frameCount == captureFrame && line == 130)
					lineBuf[10'(col)] = pixel;
			end
			else if (prevBlank)
			begin
				activeLines++;
				if (timingOn)
					checkHex("oBLANK_n active cycles", col + 1, 640);
			end
			prevHs = oHS;
			prevVs = oVS;
			prevBlank = oBLANK_n;
		end
	end

	always @(posedge VGA_CLK_n)
	begin
		cycleCount++;
		// Six frames of 800 x 525 cycles
		if (cycleCount >= 6 * int'(H_TOTAL) * int'(V_TOTAL))
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic timingTest();
		int target;
		target = vsFalls + 2;
		timingOn = 1'b1;
		wait (vsFalls >= target);
		timingOn = 1'b0;
	endtask

	task automatic registerTest();
		wbData_t words [0:7];
		wbData_t got;
		for (int a = 0; a < 8; a++)
		begin
			words[a] = $random(seed);
			wbWrite(3'(a), words[a]);
		end
		for (int a = 0; a < 8; a++)
		begin
			wbRead(3'(a), got);
			checkHex($sformatf("datOut word %0d", a), got, (a < 6) ? words[a] : 32'h0);
		end
	endtask

	task automatic backgroundTest();
		for (int a = 0; a < 6; a++)
			wbWrite(3'(a), 32'h0);
		checkFrom = frameCount + 1;
		checkUntil = frameCount + 2;
		wait (frameCount == checkFrom);
		waitLine(100);
	endtask

	task automatic priorityTest();
		wbWrite(3'd0, {16'd100, 16'd100});
		wbWrite(3'd1, {16'd60, 16'd80});
		wbWrite(3'd2, {16'd120, 16'd140});
		wbWrite(3'd3, {16'd80, 16'd100});
		wbWrite(3'd4, {16'd150, 16'd60});
		wbWrite(3'd5, {16'd120, 16'd300});
		captureFrame = frameCount + 1;
		checkUntil = frameCount + 2;
		wait (frameCount == captureFrame);
		waitLine(131);
		// Line 130 runs through P1 and then P2
		checkHex("pixel x=99", 32'(lineBuf[99]), 32'(backgroundColour(99, 130)));
		checkHex("pixel x=100", 32'(lineBuf[100]), 32'(P1_COLOR));
		checkHex("pixel x=179", 32'(lineBuf[179]), 32'(P1_COLOR));
		checkHex("pixel x=180", 32'(lineBuf[180]), 32'(P2_COLOR));
		checkHex("pixel x=239", 32'(lineBuf[239]), 32'(P2_COLOR));
		checkHex("pixel x=240", 32'(lineBuf[240]), 32'(backgroundColour(240, 130)));
	endtask

	task automatic boundaryTest();
		waitLine(140);
		// P2 jumps to y=300 while rows of its old place are still ahead
		wbWrite(3'd2, {16'd300, 16'd140});
		checkUntil = frameCount + 2;
		wait (frameCount == checkUntil);
	endtask

	initial
	begin
		iRST_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		seed = 32'ha75d4d0f;
		for (int k = 0; k < 3; k++)
			pendingRef[k] = '0;
		activeRef = pendingRef;
		$readmemh("rtl/bgTiles.hex", tileRef);
		repeat (3) @(negedge VGA_CLK_n);
		iRST_n = 1'b1;
		timingTest();
		registerTest();
		backgroundTest();
		priorityTest();
		boundaryTest();
		assert (pixelChecks == 3 * 640 * 480)
		else
		begin
			errors++;
			$display("Only %0d pixels were compared with the model", pixelChecks);
		end
		$display("Errors: %0d (testbench %0d, checker %0d)", errors + uut.chk.failures,
			errors, uut.chk.failures);
		if (errors + uut.chk.failures == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
